// File: src/tdc_macros.svh
`ifndef TDC_MACROS_SVH
`define TDC_MACROS_SVH

//------------------------------
// widths
//------------------------------
`define TDC_PHASE_W    16                          // DLL taps
`define TDC_SPAD_W     16                          // 4x4 pixel
`define TDC_FINE_W     4
`define TDC_TOF_W      15
`define TDC_COARSE_W   (`TDC_TOF_W - `TDC_FINE_W)  // cycle count part of a tof
`define TDC_INT_W      4

//------------------------------
// limits and constants
//------------------------------
`define TDC_MAX_HITS   3                           // hits kept per measurement
`define TDC_NO_HIT_TOF 15'h7fff                    // marker beat data
`define TDC_RANGE_RST  15'h7fff                    // longest window out of reset

`endif

// File: src/tdc_time_pkg.sv
`include "tdc_macros.svh"

package tdc_time_pkg;

    //------------------------------
    // raw timing inputs
    //------------------------------

    // thermometer word sampled from the DLL
    typedef logic [`TDC_PHASE_W-1:0] phase_t;

    //------------------------------
    // decoded time
    //------------------------------

    // ones in the phase word, sub-cycle position
    typedef logic [`TDC_FINE_W-1:0] fine_t;

    // clk cycles since start
    typedef logic [`TDC_COARSE_W-1:0] coarse_t;

    // {coarse, fine}, range uses the same units
    typedef logic [`TDC_TOF_W-1:0] tof_t;

endpackage

// File: src/tdc_frame_pkg.sv
`include "tdc_macros.svh"

package tdc_frame_pkg;

    //------------------------------
    // pixel side
    //------------------------------
    typedef logic [`TDC_SPAD_W-1:0] spad_t;    // one bit per SPAD

    // saturated count of enabled SPADs
    typedef logic [`TDC_INT_W-1:0] int_t;

    //------------------------------
    // frame side
    //------------------------------

    // 0 .. TDC_MAX_HITS, also the num field of a beat
    typedef logic [$clog2(`TDC_MAX_HITS+1)-1:0] hit_cnt_t;

endpackage

// File: src/tdc_cfg_regs.sv
`include "tdc_macros.svh"

module tdc_cfg_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  tdc_time_pkg::tof_t  range_i,
    input  logic                frame_done_i,   // last beat accepted
    output tdc_time_pkg::tof_t  range_o,
    output logic                busy_o
);

    logic start_ok;

    // a start only counts while idle
    assign start_ok = start_i & ~busy_o;

    //------------------------------
    // busy flag
    //------------------------------
    // high from an accepted start to the end of the frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
        end else if (start_ok) begin
            busy_o <= 1'b1;
        end else if (frame_done_i) begin
            busy_o <= 1'b0;
        end
    end

    //------------------------------
    // range register
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            range_o <= `TDC_RANGE_RST;
        end else if (start_ok) begin
            range_o <= range_i;     // held for the whole measurement
        end
    end

endmodule

// File: src/tdc_coarse_counter.sv
`include "tdc_macros.svh"

module tdc_coarse_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  logic                   busy_i,
    input  tdc_time_pkg::tof_t     range_i,       // latched range
    output logic                   window_o,
    output tdc_time_pkg::coarse_t  coarse_o,
    output logic                   window_end_o
);

    logic                  start_ok;
    logic                  at_limit;
    tdc_time_pkg::coarse_t range_coarse;

    assign start_ok     = start_i & ~busy_i;   // same condition as cfg_regs
    assign range_coarse = range_i[`TDC_TOF_W-1 -: `TDC_COARSE_W];  // drop fine bits
    assign at_limit     = (coarse_o == range_coarse);

    //------------------------------
    // window and count
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_o     <= 1'b0;
            coarse_o     <= '0;
            window_end_o <= 1'b0;
        end else begin
            window_end_o <= 1'b0;                  // single cycle pulse
            if (start_ok) begin
                window_o <= 1'b1;
                coarse_o <= '0;                    // 0 in first window cycle
            end else if (window_o) begin
                if (at_limit) begin
                    window_o     <= 1'b0;
                    window_end_o <= 1'b1;
                end else begin
                    coarse_o <= coarse_o + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/tdc_hit_capture.sv
`include "tdc_macros.svh"

module tdc_hit_capture (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    trigger_i,
    input  tdc_time_pkg::phase_t    phase_i,
    input  tdc_frame_pkg::spad_t    spad_i,
    input  logic                    window_i,
    input  tdc_time_pkg::coarse_t   coarse_i,
    output tdc_frame_pkg::hit_cnt_t hit_cnt_o,
    output tdc_time_pkg::tof_t      hit_tof_o [`TDC_MAX_HITS],
    output tdc_frame_pkg::int_t     hit_int_o [`TDC_MAX_HITS]
);

    //------------------------------
    // popcount, clipped to 4 bits
    //------------------------------
    // phase word and spad mask are both 16 wide
    function automatic logic [3:0] sat_count(input logic [`TDC_PHASE_W-1:0] word);
        logic [4:0] ones;
        ones = '0;
        for (int i = 0; i < `TDC_PHASE_W; i++) begin
            ones = ones + 5'(word[i]);
        end
        return ones[4] ? 4'hf : ones[3:0];   // all 16 set reads as 15
    endfunction

    logic                    trig_q;      // trigger last cycle
    logic                    win_q;       // window last cycle
    logic                    hit;
    logic                    win_open;
    logic                    store;
    tdc_frame_pkg::hit_cnt_t slot;
    tdc_time_pkg::fine_t     fine;
    tdc_frame_pkg::int_t     intensity;

    //------------------------------
    // edge detect and decode
    //------------------------------
    assign hit      = window_i & trigger_i & ~trig_q;    // rising edge inside window
    assign win_open = window_i & ~win_q;

    // first cycle of a new window starts over at slot 0
    assign slot  = win_open ? '0 : hit_cnt_o;
    assign store = hit & (slot != tdc_frame_pkg::hit_cnt_t'(`TDC_MAX_HITS));

    assign fine      = sat_count(phase_i);
    assign intensity = sat_count(spad_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_q <= 1'b0;
            win_q  <= 1'b0;
        end else begin
            trig_q <= trigger_i;
            win_q  <= window_i;
        end
    end

    //------------------------------
    // hit counter
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt_o <= '0;
        end else if (store) begin
            hit_cnt_o <= slot + 2'd1;
        end else if (win_open) begin
            hit_cnt_o <= '0;        // clear stale count from last frame
        end
    end

    //------------------------------
    // hit records
    //------------------------------
    // filled in arrival order, extra triggers dropped
    always_ff @(posedge clk) begin
        if (store) begin
            hit_tof_o[slot] <= {coarse_i, fine};
            hit_int_o[slot] <= intensity;
        end
    end

endmodule

// File: src/tdc_readout.sv
`include "tdc_macros.svh"

module tdc_readout (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    window_end_i,
    input  tdc_frame_pkg::hit_cnt_t hit_cnt_i,
    input  tdc_time_pkg::tof_t      hit_tof_i [`TDC_MAX_HITS],
    input  tdc_frame_pkg::int_t     hit_int_i [`TDC_MAX_HITS],
    input  logic                    ready_i,
    output tdc_time_pkg::tof_t      data_o,
    output tdc_frame_pkg::int_t     int_o,
    output tdc_frame_pkg::hit_cnt_t num_o,        // hit count, same on every beat
    output logic                    last_o,
    output logic                    valid_o,
    output logic                    frame_done_o
);

    typedef enum logic {
        S_IDLE,     // no frame in flight
        S_BEAT      // beat on the port, held while ready_i is low
    } state_t;

    state_t                  state_q;
    tdc_frame_pkg::hit_cnt_t idx_q;
    tdc_frame_pkg::hit_cnt_t idx_nxt;
    logic                    launch;
    logic                    accept;

    assign launch       = (state_q == S_IDLE) & window_end_i;
    assign accept       = valid_o & ready_i;
    assign idx_nxt      = idx_q + 2'd1;
    assign frame_done_o = accept & last_o;

    //------------------------------
    // burst FSM
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (window_end_i) begin
                        state_q <= S_BEAT;
                        idx_q   <= '0;
                        valid_o <= 1'b1;
                        last_o  <= (hit_cnt_i <= 2'd1);   // marker or single hit
                    end
                end
                S_BEAT: begin
                    // no accept keeps everything steady
                    if (accept && last_o) begin
                        state_q <= S_IDLE;
                        valid_o <= 1'b0;
                        last_o  <= 1'b0;
                    end else if (accept) begin
                        idx_q   <= idx_nxt;
                        last_o  <= (idx_nxt == num_o - 2'd1);
                    end
                end
            endcase
        end
    end

    //------------------------------
    // beat payload
    //------------------------------
    always_ff @(posedge clk) begin
        if (launch) begin
            num_o <= hit_cnt_i;
            if (hit_cnt_i == '0) begin
                data_o <= `TDC_NO_HIT_TOF;
                int_o  <= '0;
            end else begin
                data_o <= hit_tof_i[0];
                int_o  <= hit_int_i[0];
            end
        end else if (accept && !last_o) begin
            data_o <= hit_tof_i[idx_nxt];   // next record in hit order
            int_o  <= hit_int_i[idx_nxt];
        end
    end

endmodule

// File: src/tdc_top.sv
`include "tdc_macros.svh"

module tdc_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    trigger_i,     // synchronous to clk
    input  tdc_time_pkg::phase_t    phase_i,
    input  tdc_frame_pkg::spad_t    spad_i,
    input  tdc_time_pkg::tof_t      range_i,
    input  logic                    ready_i,
    output tdc_time_pkg::tof_t      data_o,
    output tdc_frame_pkg::int_t     int_o,
    output tdc_frame_pkg::hit_cnt_t num_o,
    output logic                    last_o,
    output logic                    valid_o,
    output logic                    busy_o
);

    tdc_time_pkg::tof_t      range;
    logic                    window;
    tdc_time_pkg::coarse_t   coarse;
    logic                    window_end;
    tdc_frame_pkg::hit_cnt_t hit_cnt;
    tdc_time_pkg::tof_t      hit_tof [`TDC_MAX_HITS];
    tdc_frame_pkg::int_t     hit_int [`TDC_MAX_HITS];
    logic                    frame_done;

    //------------------------------
    // config and window
    //------------------------------
    tdc_cfg_regs u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .range_i      (range_i),
        .frame_done_i (frame_done),
        .range_o      (range),
        .busy_o       (busy_o)
    );

    tdc_coarse_counter u_cnt (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .busy_i       (busy_o),
        .range_i      (range),
        .window_o     (window),
        .coarse_o     (coarse),
        .window_end_o (window_end)
    );

    //------------------------------
    // capture and readout
    //------------------------------
    tdc_hit_capture u_cap (
        .clk       (clk),
        .rst_n     (rst_n),
        .trigger_i (trigger_i),
        .phase_i   (phase_i),
        .spad_i    (spad_i),
        .window_i  (window),
        .coarse_i  (coarse),
        .hit_cnt_o (hit_cnt),
        .hit_tof_o (hit_tof),
        .hit_int_o (hit_int)
    );

    tdc_readout u_rd (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_end_i (window_end),
        .hit_cnt_i    (hit_cnt),
        .hit_tof_i    (hit_tof),
        .hit_int_i    (hit_int),
        .ready_i      (ready_i),
        .data_o       (data_o),
        .int_o        (int_o),
        .num_o        (num_o),
        .last_o       (last_o),
        .valid_o      (valid_o),
        .frame_done_o (frame_done)
    );

endmodule

// File: verification/tdc_properties.sv
module tdc_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    window_i,
    input logic                    window_end_i,
    input logic                    busy_i,
    input logic                    valid_i,
    input logic                    ready_i,
    input logic                    last_i,
    input tdc_time_pkg::tof_t      data_i,
    input tdc_frame_pkg::int_t     int_i,
    input tdc_frame_pkg::hit_cnt_t num_i
);
    timeunit 1ns;
    timeprecision 1ns;

    // stalled beat keeps its payload
    stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(int_i)
                                && $stable(num_i) && $stable(last_i))
        else $error("beat changed while ready was low");

    last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        last_i |-> valid_i)
        else $error("last set without valid");

    // busy spans the whole window
    busy_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        window_i |-> busy_i)
        else $error("window open while not busy");

    first_beat_after_end: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(valid_i) |-> $past(window_end_i))
        else $error("valid rose without a window end");

endmodule

bind tdc_top tdc_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_i     (window),
    .window_end_i (window_end),
    .busy_i       (busy_o),
    .valid_i      (valid_o),
    .ready_i      (ready_i),
    .last_i       (last_o),
    .data_i       (data_o),
    .int_i        (int_o),
    .num_i        (num_o)
);

// File: verification/tdc_tb.sv
`include "tdc_macros.svh"

module tdc_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLK_PERIOD  = 100;
    localparam int MAX_TRIG    = 8;
    // five tests take about 150 cycles with stalls
    localparam int CYCLE_LIMIT = 400;

    logic                    clk;
    logic                    rst_n;
    logic                    start_i;
    logic                    trigger_i;
    tdc_time_pkg::phase_t    phase_i;
    tdc_frame_pkg::spad_t    spad_i;
    tdc_time_pkg::tof_t      range_i;
    logic                    ready_i;
    tdc_time_pkg::tof_t      data_o;
    tdc_frame_pkg::int_t     int_o;
    tdc_frame_pkg::hit_cnt_t num_o;
    logic                    last_o;
    logic                    valid_o;
    logic                    busy_o;

    logic [31:0] rng_state;
    int          cycles = 0;
    int          tof_errs;
    int          int_errs;
    int          num_errs;
    int          bit_errs;

    // trigger schedule of the next measurement
    int                      trig_cyc [MAX_TRIG];
    tdc_time_pkg::phase_t    trig_phase [MAX_TRIG];
    tdc_frame_pkg::spad_t    trig_spad [MAX_TRIG];
    int                      n_trig;

    // expected frame
    tdc_time_pkg::tof_t      exp_tof [`TDC_MAX_HITS];
    tdc_frame_pkg::int_t     exp_int [`TDC_MAX_HITS];
    tdc_frame_pkg::hit_cnt_t exp_cnt;

    tdc_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .trigger_i (trigger_i),
        .phase_i   (phase_i),
        .spad_i    (spad_i),
        .range_i   (range_i),
        .ready_i   (ready_i),
        .data_o    (data_o),
        .int_o     (int_o),
        .num_o     (num_o),
        .last_o    (last_o),
        .valid_o   (valid_o),
        .busy_o    (busy_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the frame never completed", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    //------------------------------
    // random numbers and model
    //------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // fine code is the number of DLL taps passed, clipped at 15
    function automatic tdc_time_pkg::fine_t fine_model(input tdc_time_pkg::phase_t p);
        int n;
        n = $countones(p);
        return (n > 15) ? 4'hf : tdc_time_pkg::fine_t'(n);
    endfunction

    function automatic tdc_frame_pkg::int_t int_model(input tdc_frame_pkg::spad_t s);
        int n;
        n = $countones(s);
        return (n > 15) ? 4'hf : tdc_frame_pkg::int_t'(n);
    endfunction

    //------------------------------
    // compare tasks
    //------------------------------
    task automatic check_tof(input tdc_time_pkg::tof_t got, input tdc_time_pkg::tof_t exp,
                             input string what);
        if (got !== exp) begin
            tof_errs++;
            $display("** Error @%0t: %s tof got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input tdc_frame_pkg::int_t got, input tdc_frame_pkg::int_t exp,
                             input string what);
        if (got !== exp) begin
            int_errs++;
            $display("** Error @%0t: %s intensity got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_num(input tdc_frame_pkg::hit_cnt_t got,
                             input tdc_frame_pkg::hit_cnt_t exp, input string what);
        if (got !== exp) begin
            num_errs++;
            $display("** Error @%0t: %s num got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bit_errs++;
            $display("** Error @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    //------------------------------
    // stimulus
    //------------------------------
    task automatic add_trigger(input int cyc, input tdc_time_pkg::phase_t p,
                               input tdc_frame_pkg::spad_t s);
        trig_cyc[n_trig]   = cyc;
        trig_phase[n_trig] = p;
        trig_spad[n_trig]  = s;
        n_trig++;
    endtask

    // cyc counts window cycles, the coarse count seen by the capture
    task automatic run_measurement(input tdc_time_pkg::coarse_t r, input int busy_start);
        logic [31:0] rnd;
        int          cyc;
        int          k;
        int          hits;
        int          last_cyc;
        k        = 0;
        hits     = 0;
        last_cyc = int'(r);
        if (n_trig > 0 && trig_cyc[n_trig-1] + 1 > last_cyc) begin
            last_cyc = trig_cyc[n_trig-1] + 1;
        end
        rnd = next_random();
        @(negedge clk);
        ready_i = 1'b0;                    // beats wait until readout
        start_i = 1'b1;
        range_i = {r, rnd[3:0]};           // fine bits of the range do not matter
        for (cyc = 0; cyc <= last_cyc; cyc++) begin
            @(negedge clk);
            // first beat two cycles after the last window cycle
            check_bit(valid_o, cyc >= int'(r) + 2, "valid timing");
            start_i   = (cyc == busy_start);
            trigger_i = 1'b0;
            phase_i   = tdc_time_pkg::phase_t'(next_random());
            spad_i    = tdc_frame_pkg::spad_t'(next_random());
            if (cyc == busy_start) begin
                range_i = {11'd2, 4'd0};   // short range, must be ignored
                check_bit(busy_o, 1'b1, "busy during window");
            end
            if (k < n_trig && trig_cyc[k] == cyc) begin
                trigger_i = 1'b1;
                phase_i   = trig_phase[k];
                spad_i    = trig_spad[k];
                if (cyc <= int'(r) && hits < `TDC_MAX_HITS) begin
                    exp_tof[hits] = {tdc_time_pkg::coarse_t'(cyc), fine_model(phase_i)};
                    exp_int[hits] = int_model(spad_i);
                    hits++;
                end
                k++;
            end
        end
        @(negedge clk);
        trigger_i = 1'b0;
        start_i   = 1'b0;
        exp_cnt   = tdc_frame_pkg::hit_cnt_t'(hits);
    endtask

    // takes beats until the expected count is in, then checks that busy fell
    task automatic receive_frame(input logic stall, input string name);
        logic [31:0] rnd;
        int          beats;
        int          seen;
        string       what;
        beats = (exp_cnt == 2'd0) ? 1 : int'(exp_cnt);
        seen  = 0;
        while (seen < beats) begin
            @(negedge clk);
            rnd     = next_random();
            ready_i = stall ? rnd[0] : 1'b1;
            if (valid_o && ready_i) begin
                what = $sformatf("%s beat %0d", name, seen);
                if (exp_cnt == 2'd0) begin
                    check_tof(data_o, `TDC_NO_HIT_TOF, what);   // marker beat
                    check_int(int_o, '0, what);
                end else begin
                    check_tof(data_o, exp_tof[seen], what);
                    check_int(int_o, exp_int[seen], what);
                end
                check_num(num_o, exp_cnt, what);
                check_bit(last_o, seen == beats - 1, {what, " last"});
                seen++;
            end
        end
        @(negedge clk);
        ready_i = 1'b0;
        check_bit(valid_o, 1'b0, {name, " valid after frame"});
        check_bit(busy_o, 1'b0, {name, " busy after frame"});
    endtask

    //------------------------------
    // tests
    //------------------------------
    task automatic test_no_hits();
        n_trig = 0;
        run_measurement(11'd8, -1);
        receive_frame(1'b0, "no hits");
    endtask

    task automatic test_one_hit();
        n_trig = 0;
        add_trigger(5, 16'h00ff, 16'hffff);    // fine 8, intensity clipped
        run_measurement(11'd20, -1);
        receive_frame(1'b0, "one hit");
    endtask

    task automatic test_many_hits();
        n_trig = 0;
        add_trigger(2, tdc_time_pkg::phase_t'(next_random()), 16'h0f0f);
        add_trigger(6, 16'hffff, tdc_frame_pkg::spad_t'(next_random()));
        add_trigger(11, tdc_time_pkg::phase_t'(next_random()), 16'h0001);
        add_trigger(15, 16'h0003, 16'h0003);   // fourth, dropped
        run_measurement(11'd20, -1);
        receive_frame(1'b0, "many hits");
    endtask

    task automatic test_range();
        n_trig = 0;
        add_trigger(1, 16'h0007, 16'h00f0);
        add_trigger(4, 16'h7fff, 16'h0000);    // last window cycle
        add_trigger(7, 16'h0001, 16'h0001);    // after the window
        run_measurement(11'd4, -1);
        receive_frame(1'b0, "range");
    endtask

    task automatic test_backpressure();
        n_trig = 0;
        add_trigger(3, tdc_time_pkg::phase_t'(next_random()),
                    tdc_frame_pkg::spad_t'(next_random()));
        add_trigger(9, tdc_time_pkg::phase_t'(next_random()),
                    tdc_frame_pkg::spad_t'(next_random()));
        add_trigger(14, tdc_time_pkg::phase_t'(next_random()),
                    tdc_frame_pkg::spad_t'(next_random()));
        run_measurement(11'd18, 6);            // start while busy at cycle 6
        receive_frame(1'b1, "stall a");
        n_trig = 0;
        add_trigger(1, 16'h03ff, 16'h5555);
        add_trigger(9, 16'h0000, 16'hffff);
        run_measurement(11'd10, -1);
        receive_frame(1'b1, "stall b");
    endtask

    initial begin
        rng_state = 32'd73;
        tof_errs  = 0;
        int_errs  = 0;
        num_errs  = 0;
        bit_errs  = 0;
        n_trig    = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        start_i   = 1'b0;
        trigger_i = 1'b0;
        phase_i   = '0;
        spad_i    = '0;
        range_i   = '0;
        ready_i   = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_bit(busy_o, 1'b0, "busy after reset");
        check_bit(valid_o, 1'b0, "valid after reset");

        test_no_hits();
        test_one_hit();
        test_many_hits();
        test_range();
        test_backpressure();

        $display("errors: tof %0d, intensity %0d, num %0d, flags %0d",
                 tof_errs, int_errs, num_errs, bit_errs);
        if (tof_errs + int_errs + num_errs + bit_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/tdc_time_pkg.sv
src/tdc_frame_pkg.sv
src/tdc_cfg_regs.sv
src/tdc_coarse_counter.sv
src/tdc_hit_capture.sv
src/tdc_readout.sv
src/tdc_top.sv
verification/tdc_properties.sv
verification/tdc_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tdc_tb -f vlog.f -o tdc_sim
	out="$$(./obj_dir/tdc_sim)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
